//--- rtl/dmss_pkg.sv
// dmss shared definitions
// data types, access size encoding and data memory geometry
// used by every block of the data memory subsystem
package dmss_pkg;

    // one memory byte
    typedef logic [7:0] byte_t;

    // data word as seen by the core
    typedef logic [31:0] word_t;

    // byte address, used as physical
    typedef logic [31:0] vaddr_t;

    // access size
    // same as funct3[1:0] of RISC-V loads and stores
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b10
    } size_t;

    // memory size in bytes
    // addresses wrap modulo this size
    localparam int DMEM_BYTES = 4096;

    // word index width, 1024 words
    localparam int DMEM_WORD_AW = $clog2(DMEM_BYTES / 4);

endpackage : dmss_pkg

//--- rtl/dmss_req_stage.sv
// dmss request stage
// checks alignment of an incoming load or store, steers store bytes
// onto the addressed lanes with byte enables, and registers the
// control that the response stage needs one cycle later
`timescale 1ns/1ps

module dmss_req_stage (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              req_load,
    input  logic                              req_store,
    input  dmss_pkg::vaddr_t                  req_addr,
    input  dmss_pkg::size_t                   req_size,
    input  logic                              req_unsigned,
    input  dmss_pkg::word_t                   req_store_data,
    input  logic                              stall,
    output logic                              wr_en,
    output logic [3:0]                        wr_be,
    output dmss_pkg::word_t                   wr_data,
    output logic                              rd_en,
    output logic [dmss_pkg::DMEM_WORD_AW-1:0] word_addr,
    output logic                              s1_load,
    output logic [1:0]                        s1_lane,
    output dmss_pkg::size_t                   s1_size,
    output logic                              s1_unsigned,
    output logic                              s1_misaligned
);
    import dmss_pkg::*;

    logic       accept;
    logic       misaligned;
    logic [1:0] lane;

    // request is taken on every edge without stall
    assign accept = !stall;

    // byte lane within the word
    assign lane = req_addr[1:0];

    // alignment from size and low address bits
    always_comb begin
        case (req_size)
            SIZE_HALF: misaligned = lane[0];
            SIZE_WORD: misaligned = |lane;
            default:   misaligned = 1'b0;
        endcase
    end

    // byte enables and store data replicated onto the lanes
    always_comb begin
        case (req_size)
            SIZE_BYTE: begin
                wr_be   = 4'b0001 << lane;
                wr_data = {4{req_store_data[7:0]}};
            end
            SIZE_HALF: begin
                // upper or lower halfword
                wr_be   = lane[1] ? 4'b1100 : 4'b0011;
                wr_data = {2{req_store_data[15:0]}};
            end
            default: begin
                wr_be   = 4'b1111;
                wr_data = req_store_data;
            end
        endcase
    end

    // misaligned stores never reach memory
    assign wr_en = accept && req_store && !misaligned;
    assign rd_en = accept && req_load;

    // drop lane bits, wrap to memory size
    assign word_addr = req_addr[DMEM_WORD_AW+1:2];

    // response control, cleared by reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_load       <= 1'b0;
            s1_misaligned <= 1'b0;
        end else if (accept) begin
            s1_load       <= req_load;
            // only a real access can be illegal
            s1_misaligned <= misaligned && (req_load || req_store);
        end
    end

    // extraction info for the load data
    always_ff @(posedge clk) begin
        if (accept) begin
            s1_lane     <= lane;
            s1_size     <= req_size;
            s1_unsigned <= req_unsigned;
        end
    end

endmodule : dmss_req_stage

//--- rtl/dmss_dmem.sv
// dmss data memory
// four byte lanes with separate write enables, shared word index,
// registered word read with one cycle of latency
`timescale 1ns/1ps

module dmss_dmem (
    input  logic                              clk,
    input  logic                              wr_en,
    input  logic [3:0]                        wr_be,
    input  dmss_pkg::word_t                   wr_data,
    input  logic                              rd_en,
    input  logic [dmss_pkg::DMEM_WORD_AW-1:0] word_addr,
    output dmss_pkg::word_t                   rd_word
);
    import dmss_pkg::*;

    // one array per lane, lane 0 is the lowest address byte
    for (genvar i = 0; i < 4; i++) begin : g_lane
        byte_t lane_mem [DMEM_BYTES/4];
        byte_t rd_byte;

        // write only lanes that are enabled
        always_ff @(posedge clk) begin
            if (wr_en && wr_be[i]) begin
                lane_mem[word_addr] <= wr_data[8*i +: 8];
            end
        end

        // read register holds when no load is accepted
        // read sees the old contents on a same-edge write
        always_ff @(posedge clk) begin
            if (rd_en) begin
                rd_byte <= lane_mem[word_addr];
            end
        end

        // little endian word assembly
        assign rd_word[8*i +: 8] = rd_byte;
    end

endmodule : dmss_dmem

//--- rtl/dmss_load_extract.sv
// dmss load extract
// picks the byte, halfword or word at the registered lane from
// the read word and sign or zero extends it to 32 bits
// purely combinational, sits in the response stage
`timescale 1ns/1ps

module dmss_load_extract (
    input  dmss_pkg::word_t rd_word,
    input  logic            s1_load,
    input  logic [1:0]      s1_lane,
    input  dmss_pkg::size_t s1_size,
    input  logic            s1_unsigned,
    input  logic            s1_misaligned,
    output logic            rsp_load_valid,
    output logic            rsp_illegal,
    output dmss_pkg::word_t rsp_load_data
);
    import dmss_pkg::*;

    byte_t       sel_byte;
    logic [15:0] sel_half;
    logic        byte_sign;
    logic        half_sign;

    // byte at the addressed lane
    assign sel_byte = rd_word[{s1_lane, 3'b000} +: 8];

    // halfword, lane bit 0 is zero when aligned
    assign sel_half = s1_lane[1] ? rd_word[31:16] : rd_word[15:0];

    // fill bits, forced low for unsigned loads
    assign byte_sign = sel_byte[7] && !s1_unsigned;
    assign half_sign = sel_half[15] && !s1_unsigned;

    always_comb begin
        case (s1_size)
            SIZE_BYTE: rsp_load_data = {{24{byte_sign}}, sel_byte};
            SIZE_HALF: rsp_load_data = {{16{half_sign}}, sel_half};
            // word and unused code pass the whole word
            default:   rsp_load_data = rd_word;
        endcase
    end

    // status straight from the stage-1 registers
    // misaligned loads still show valid, data is don't-care then
    assign rsp_load_valid = s1_load;
    assign rsp_illegal    = s1_misaligned;

endmodule : dmss_load_extract

//--- rtl/dmss.sv
// dmss top level
// data memory subsystem for the load/store stage
// stage 0 takes the request and writes memory, stage 1 returns
// load data and the illegal flag one edge later
// stall holds the response and blocks new requests
`timescale 1ns/1ps

module dmss (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             req_load,
    input  logic             req_store,
    input  dmss_pkg::vaddr_t req_addr,
    input  dmss_pkg::size_t  req_size,
    input  logic             req_unsigned,
    input  dmss_pkg::word_t  req_store_data,
    input  logic             stall,
    output logic             rsp_load_valid,
    output logic             rsp_illegal,
    output dmss_pkg::word_t  rsp_load_data
);
    import dmss_pkg::*;

    // stage 0 to memory
    logic                    wr_en;
    logic [3:0]              wr_be;
    word_t                   wr_data;
    logic                    rd_en;
    logic [DMEM_WORD_AW-1:0] word_addr;

    // stage 1 control to extraction
    logic                    s1_load;
    logic [1:0]              s1_lane;
    size_t                   s1_size;
    logic                    s1_unsigned;
    logic                    s1_misaligned;

    // memory read word
    word_t                   rd_word;

    dmss_req_stage u_req_stage (
        .clk            (clk),
        .rst_n          (rst_n),
        .req_load       (req_load),
        .req_store      (req_store),
        .req_addr       (req_addr),
        .req_size       (req_size),
        .req_unsigned   (req_unsigned),
        .req_store_data (req_store_data),
        .stall          (stall),
        .wr_en          (wr_en),
        .wr_be          (wr_be),
        .wr_data        (wr_data),
        .rd_en          (rd_en),
        .word_addr      (word_addr),
        .s1_load        (s1_load),
        .s1_lane        (s1_lane),
        .s1_size        (s1_size),
        .s1_unsigned    (s1_unsigned),
        .s1_misaligned  (s1_misaligned)
    );

    dmss_dmem u_dmem (
        .clk       (clk),
        .wr_en     (wr_en),
        .wr_be     (wr_be),
        .wr_data   (wr_data),
        .rd_en     (rd_en),
        .word_addr (word_addr),
        .rd_word   (rd_word)
    );

    dmss_load_extract u_load_extract (
        .rd_word        (rd_word),
        .s1_load        (s1_load),
        .s1_lane        (s1_lane),
        .s1_size        (s1_size),
        .s1_unsigned    (s1_unsigned),
        .s1_misaligned  (s1_misaligned),
        .rsp_load_valid (rsp_load_valid),
        .rsp_illegal    (rsp_illegal),
        .rsp_load_data  (rsp_load_data)
    );

endmodule : dmss

//--- verification/dmss_assert.sv
// dmss protocol checks
// reset values of the response flags, illegal flag timing,
// response hold under stall and load valid timing
// bound to the dmss top level
`timescale 1ns/1ps

module dmss_assert (
    input logic             clk,
    input logic             rst_n,
    input logic             req_load,
    input logic             req_store,
    input dmss_pkg::vaddr_t req_addr,
    input dmss_pkg::size_t  req_size,
    input logic             stall,
    input logic             rsp_load_valid,
    input logic             rsp_illegal,
    input dmss_pkg::word_t  rsp_load_data
);
    import dmss_pkg::*;

    logic accept;
    logic bad_access;
    int   fail_count = 0;

    // edge that takes a request
    assign accept = rst_n && !stall;

    // half on odd address, word off a word boundary
    assign bad_access = (req_load || req_store) &&
        ((req_size == SIZE_HALF && req_addr[0]) ||
         (req_size == SIZE_WORD && req_addr[1:0] != 2'b00));

    a_reset: assert property (@(posedge clk) !rst_n |=> !rsp_load_valid && !rsp_illegal)
        else begin
            $error("response flags high during or right after reset");
            fail_count++;
        end

    a_illegal: assert property (@(posedge clk) accept |=> rsp_illegal == $past(bad_access))
        else begin
            $error("illegal flag does not match the accepted request");
            fail_count++;
        end

    // whole response frozen across a stalled edge
    a_stall: assert property (@(posedge clk) rst_n && stall |=>
        $stable(rsp_load_valid) && $stable(rsp_illegal) && $stable(rsp_load_data))
        else begin
            $error("response changed while stalled");
            fail_count++;
        end

    a_load_valid: assert property (@(posedge clk) accept && req_load |=> rsp_load_valid)
        else begin
            $error("load valid missing after an accepted load");
            fail_count++;
        end

    a_no_valid: assert property (@(posedge clk) accept && !req_load |=> !rsp_load_valid)
        else begin
            $error("load valid high after a store or idle edge");
            fail_count++;
        end

endmodule : dmss_assert

bind dmss dmss_assert u_assert (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_load       (req_load),
    .req_store      (req_store),
    .req_addr       (req_addr),
    .req_size       (req_size),
    .stall          (stall),
    .rsp_load_valid (rsp_load_valid),
    .rsp_illegal    (rsp_illegal),
    .rsp_load_data  (rsp_load_data)
);

//--- verification/tb_dmss.sv
// dmss testbench
// random word, byte and halfword traffic against a byte reference
// model, misaligned accesses and stalled requests
// protocol timing is checked by the bound assertions
`timescale 1ns/1ps

module tb_dmss;
    import dmss_pkg::*;

    // galois lfsr mask and seed
    localparam logic [31:0] LFSR_POLY  = 32'hB4BC_D35C;
    localparam logic [31:0] LFSR_SEED  = 32'd87;
    localparam int          BYTE_AW    = $clog2(DMEM_BYTES);
    localparam int          WAIT_LIMIT = 8;
    localparam int          N_WORDS    = 24;

    logic   clk;
    logic   rst_n;
    logic   req_load;
    logic   req_store;
    vaddr_t req_addr;
    size_t  req_size;
    logic   req_unsigned;
    word_t  req_store_data;
    logic   stall;
    logic   rsp_load_valid;
    logic   rsp_illegal;
    word_t  rsp_load_data;

    logic [31:0] lfsr;
    byte_t       ref_mem [DMEM_BYTES];
    vaddr_t      addr_q [$];
    int          errors;

    dmss dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // one lfsr step per bit, msb first
    function automatic word_t rand_bits(input int n);
        word_t v;
        logic  b;
        v = '0;
        for (int i = 0; i < n; i++) begin
            b    = lfsr[0];
            lfsr = b ? ((lfsr >> 1) ^ LFSR_POLY) : (lfsr >> 1);
            v    = {v[30:0], b};
        end
        return v;
    endfunction

    function automatic logic is_misaligned(input vaddr_t addr, input size_t size);
        return (size == SIZE_HALF && addr[0]) || (size == SIZE_WORD && addr[1:0] != 2'b00);
    endfunction

    // little endian gather, then extend by size
    function automatic word_t predict_load(input vaddr_t addr, input size_t size, input logic uns);
        logic [BYTE_AW-1:0] b;
        word_t              raw;
        b   = addr[BYTE_AW-1:0];
        raw = {ref_mem[b + BYTE_AW'(3)], ref_mem[b + BYTE_AW'(2)],
               ref_mem[b + BYTE_AW'(1)], ref_mem[b]};
        case (size)
            SIZE_BYTE: return uns ? {24'b0, raw[7:0]} : {{24{raw[7]}}, raw[7:0]};
            SIZE_HALF: return uns ? {16'b0, raw[15:0]} : {{16{raw[15]}}, raw[15:0]};
            default:   return raw;
        endcase
    endfunction

    // drive one request, stalled for hold edges first
    // returns just after the accepting edge
    task automatic send_request(input logic load, input logic store, input vaddr_t addr,
                                input size_t size, input logic uns, input word_t data,
                                input int hold);
        req_load       = load;
        req_store      = store;
        req_addr       = addr;
        req_size       = size;
        req_unsigned   = uns;
        req_store_data = data;
        stall          = (hold > 0);
        for (int i = 0; i < hold; i++) begin
            @(posedge clk);
            #1;
        end
        stall = 1'b0;
        @(posedge clk);
        #1;
        req_load  = 1'b0;
        req_store = 1'b0;
    endtask

    task automatic write_mem(input vaddr_t addr, input size_t size, input word_t data,
                             input int hold);
        logic [BYTE_AW-1:0] b;
        send_request(1'b0, 1'b1, addr, size, 1'b0, data, hold);
        b = addr[BYTE_AW-1:0];
        // misaligned stores leave the model untouched
        if (!is_misaligned(addr, size)) begin
            for (int i = 0; i < (size == SIZE_BYTE ? 1 : size == SIZE_HALF ? 2 : 4); i++) begin
                ref_mem[b + BYTE_AW'(i)] = data[8*i +: 8];
            end
        end
    endtask

    task automatic read_and_check(input string name, input vaddr_t addr, input size_t size,
                                  input logic uns, input int hold);
        word_t expected;
        int    waited;
        expected = predict_load(addr, size, uns);
        send_request(1'b1, 1'b0, addr, size, uns, '0, hold);
        waited = 0;
        while (!rsp_load_valid && waited < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (!rsp_load_valid) begin
            $display("no load response for %s within %0d cycles", name, WAIT_LIMIT);
            errors++;
        end else if (!is_misaligned(addr, size)) begin
            // misaligned load data is don't-care
            assert (rsp_load_data === expected)
            else begin
                $display("[FAIL] %s: expected %08h, actual %08h", name, expected, rsp_load_data);
                errors++;
            end
        end
    endtask

    initial begin
        word_t  r;
        vaddr_t a;
        size_t  sz;
        rst_n          = 1'b0;
        // misaligned word load held through reset
        req_load       = 1'b1;
        req_store      = 1'b0;
        req_addr       = 32'h0000_0001;
        req_size       = SIZE_WORD;
        req_unsigned   = 1'b0;
        req_store_data = '0;
        stall          = 1'b0;
        lfsr           = LFSR_SEED;
        errors         = 0;
        repeat (16) @(posedge clk);
        #1;
        rst_n    = 1'b1;
        req_load = 1'b0;

        // aligned words, full 32-bit addresses so they wrap
        for (int k = 0; k < N_WORDS; k++) begin
            r = rand_bits(30);
            addr_q.push_back({r[29:0], 2'b00});
            write_mem(addr_q[k], SIZE_WORD, rand_bits(32), 0);
        end
        foreach (addr_q[k]) begin
            read_and_check("word", addr_q[k], SIZE_WORD, 1'b0, 0);
        end

        // byte and half stores into a filled word, every lane read back
        for (int k = 0; k < 6; k++) begin
            r = rand_bits(30);
            a = {r[29:0], 2'b00};
            write_mem(a, SIZE_WORD, rand_bits(32), 0);
            r = rand_bits(3);
            write_mem(a + {30'b0, r[1:0]}, SIZE_BYTE, rand_bits(32), 0);
            write_mem(a + {30'b0, r[2], 1'b0}, SIZE_HALF, rand_bits(32), 0);
            for (int i = 0; i < 4; i++) begin
                read_and_check("byte signed", a + vaddr_t'(i), SIZE_BYTE, 1'b0, 0);
                read_and_check("byte unsigned", a + vaddr_t'(i), SIZE_BYTE, 1'b1, 0);
            end
            for (int i = 0; i < 4; i += 2) begin
                read_and_check("half signed", a + vaddr_t'(i), SIZE_HALF, 1'b0, 0);
                read_and_check("half unsigned", a + vaddr_t'(i), SIZE_HALF, 1'b1, 0);
            end
            read_and_check("word after lanes", a, SIZE_WORD, 1'b0, 0);
        end

        // misaligned stores must not touch the word
        for (int k = 0; k < 4; k++) begin
            r = rand_bits(30);
            a = {r[29:0], 2'b00};
            write_mem(a, SIZE_WORD, rand_bits(32), 0);
            r  = rand_bits(3);
            sz = r[2] ? SIZE_WORD : SIZE_HALF;
            write_mem(a + {30'b0, r[1:0] | 2'b01}, sz, rand_bits(32), 0);
            write_mem(a + 32'd2, SIZE_WORD, rand_bits(32), 0);
            read_and_check("misaligned load", a + 32'd1, sz, 1'b0, 0);
            read_and_check("word after misaligned", a, SIZE_WORD, 1'b0, 0);
        end

        // requests held under stall
        r = rand_bits(30);
        a = {r[29:0], 2'b00};
        write_mem(a, SIZE_WORD, rand_bits(32), 3);
        read_and_check("stalled word", a, SIZE_WORD, 1'b0, 2);
        write_mem(a + 32'd3, SIZE_BYTE, rand_bits(32), 1);
        read_and_check("stalled byte", a + 32'd3, SIZE_BYTE, 1'b0, 4);
        read_and_check("stalled half", a + 32'd2, SIZE_HALF, 1'b1, 2);

        // idle edges after the last load
        repeat (4) @(posedge clk);
        #1;
        $display("load check errors %0d, assertion failures %0d",
                 errors, dut.u_assert.fail_count);
        if (errors == 0 && dut.u_assert.fail_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule : tb_dmss

//--- dmss.f
rtl/dmss_pkg.sv
rtl/dmss_req_stage.sv
rtl/dmss_dmem.sv
rtl/dmss_load_extract.sv
rtl/dmss.sv
verification/dmss_assert.sv
verification/tb_dmss.sv

//--- Makefile
# Verilator build and run of the dmss testbench

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tb_dmss -f dmss.f -o Vtb_dmss
	./obj_dir/Vtb_dmss +verilator+error+limit+1000 > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "Errors found" sim.log; then exit 1; fi
	@grep -q "No errors" sim.log

clean:
	rm -rf obj_dir sim.log
